// ==== rtl/lane_buf_pkg.sv ====
// lane buffer package with lane sizing constants, opcode and drain state types
package lane_buf_pkg;

	// ==============================
	// lane geometry
	// ==============================

	// number of lane fifos
	localparam int NUM_LANES = 4;
	// lane number width
	localparam int LANE_BITS = 2;
	// payload width
	localparam int DATA_W = 16;
	// log2 of lane depth, also initial upstream credits per lane
	localparam int LANE_DEPTH_BITS = 3;
	// stored entry is last bit on top of payload
	localparam int ENTRY_W = DATA_W + 1;

	// ==============================
	// downstream credit
	// ==============================

	// credits held by the drain after reset
	localparam int OUT_CREDITS = 4;
	// headroom above OUT_CREDITS for early returns
	localparam int CRD_W = 4;

	// ingress opcode
	typedef enum logic {
		OP_DATA = 1'b0,
		OP_LAST = 1'b1
	} lane_op_e;

	// drain fsm states
	typedef enum logic {
		DR_PICK  = 1'b0,
		DR_BURST = 1'b1
	} drain_state_e;

endpackage

// ==== rtl/flop_fifo.sv ====
// flop storage FIFO with circular pointers, next count and near-full and near-empty flags
module flop_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH_BITS = 3,
	parameter int DEPTH = 1 << DEPTH_BITS
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [WIDTH-1:0]      din,
	input  logic                  wr,
	input  logic                  rd,
	output logic [WIDTH-1:0]      dout,
	output logic [DEPTH_BITS:0]   ncount,
	output logic                  full,
	output logic                  empty,
	output logic                  fullm1,
	output logic                  emptyp1
);

	// ==============================
	// storage and pointers
	// ==============================

	// DEPTH may be less than 2**DEPTH_BITS
	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	// registered occupancy
	logic [DEPTH_BITS:0]   count;

	// pointer step with wrap at DEPTH-1
	function automatic logic [DEPTH_BITS-1:0] ptr_inc(input logic [DEPTH_BITS-1:0] p);
		if (p == DEPTH_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// no reset on the array
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= ncount;
		end
	end

	// ==============================
	// outputs
	// ==============================

	// head word, straight off the array
	assign dout = mem[rd_ptr];

	// next count, combinational
	assign ncount = count + {{DEPTH_BITS{1'b0}}, wr} - {{DEPTH_BITS{1'b0}}, rd};

	// flags from registered count
	assign full    = (count == (DEPTH_BITS+1)'(DEPTH));
	assign fullm1  = (count == (DEPTH_BITS+1)'(DEPTH - 1));
	assign empty   = (count == '0);
	assign emptyp1 = (count == (DEPTH_BITS+1)'(1));

	// caller must respect the flags
	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr && full))
		else $error("flop_fifo write while full");
	a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
		else $error("flop_fifo read while empty");

endmodule

// ==== rtl/fifo_flop_out.sv ====
// output-registered FIFO keeping its head word in a flop in front of a flop storage FIFO
module fifo_flop_out #(
	parameter int WIDTH = 16,
	parameter int DEPTH_BITS = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [WIDTH-1:0]      din,
	input  logic                  wr,
	input  logic                  rd,
	output logic [WIDTH-1:0]      dout,
	output logic [DEPTH_BITS:0]   count,
	output logic                  full,
	output logic                  empty,
	output logic                  emptyp2
);

	// ==============================
	// inner fifo signals
	// ==============================

	logic [WIDTH-1:0]    ff_dout;
	logic [DEPTH_BITS:0] ff_ncount;
	logic                ff_full;
	logic                ff_empty;
	logic                ff_emptyp1;
	logic                ff_wr;
	logic                ff_rd;
	// next state of the output flop
	logic                nempty;
	logic [DEPTH_BITS:0] ncount;

	// refill only when the inner fifo has something
	assign ff_rd = rd && !ff_empty;
	// bypass when empty, or one entry turning over in place
	assign ff_wr = wr && !(empty || (ff_empty && rd));

	// read+write or idle keeps empty as is
	// write alone fills, read alone empties if nothing behind
	assign nempty = (wr == rd) ? empty : (!wr && rd && ff_empty);

	// inner count plus the output flop
	assign ncount = ff_ncount + {{DEPTH_BITS{1'b0}}, !nempty};

	// inner full means every slot plus the head is taken
	assign full    = ff_full;
	// one behind the head means two in total
	assign emptyp2 = ff_emptyp1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			empty <= 1'b1;
			count <= '0;
		end else begin
			empty <= nempty;
			count <= ncount;
		end
	end

	// head flop
	// load on a read, or on a write into an empty buffer
	always_ff @(posedge clk) begin
		if ((wr && empty) || rd) begin
			dout <= (rd && !ff_empty) ? ff_dout : din;
		end
	end

	// ==============================
	// storage behind the head
	// ==============================

	flop_fifo #(
		.WIDTH      (WIDTH),
		.DEPTH_BITS (DEPTH_BITS),
		.DEPTH      ((1 << DEPTH_BITS) - 1)
	) store_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (din),
		.wr      (ff_wr),
		.rd      (ff_rd),
		.dout    (ff_dout),
		.ncount  (ff_ncount),
		.full    (ff_full),
		.empty   (ff_empty),
		.fullm1  (),
		.emptyp1 (ff_emptyp1)
	);

	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr && full))
		else $error("fifo_flop_out write while full");
	a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
		else $error("fifo_flop_out read while empty");

endmodule

// ==== rtl/lane_dispatch.sv ====
// lane dispatcher registering ingress words against per-lane upstream credit
module lane_dispatch (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_valid,
	input  logic [lane_buf_pkg::LANE_BITS-1:0]    in_lane,
	input  lane_buf_pkg::lane_op_e                in_op,
	input  logic [lane_buf_pkg::DATA_W-1:0]       in_data,
	input  logic [lane_buf_pkg::NUM_LANES-1:0]    credit_ret,
	output logic [lane_buf_pkg::NUM_LANES-1:0]    lane_wr,
	output logic [lane_buf_pkg::ENTRY_W-1:0]      lane_din,
	output logic                                  overrun
);

	import lane_buf_pkg::*;

	// ==============================
	// credit balances
	// ==============================

	// one balance per lane, 0..depth
	logic [NUM_LANES-1:0][LANE_DEPTH_BITS:0] bal_q;
	// word accepted for lane
	logic [NUM_LANES-1:0]                    take;
	// word arrived with no credit
	logic [NUM_LANES-1:0]                    starve;

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_bal
		logic sel;

		assign sel       = in_valid && (in_lane == LANE_BITS'(i));
		assign take[i]   = sel && (bal_q[i] != '0);
		assign starve[i] = sel && (bal_q[i] == '0);

		// starts full, one per fifo entry
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				bal_q[i] <= (LANE_DEPTH_BITS+1)'(1 << LANE_DEPTH_BITS);
			end else begin
				bal_q[i] <= bal_q[i] + {{LANE_DEPTH_BITS{1'b0}}, credit_ret[i]}
					- {{LANE_DEPTH_BITS{1'b0}}, take[i]};
			end
		end

		// drain returns no more than was taken
		a_bal_max: assert property (@(posedge clk) disable iff (!rst_n)
			bal_q[i] <= (LANE_DEPTH_BITS+1)'(1 << LANE_DEPTH_BITS))
			else $error("lane %0d credit balance above depth", i);
	end

	// ==============================
	// ingress register
	// ==============================

	// write strobe one edge after accept; overrun is sticky
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_wr <= '0;
			overrun <= 1'b0;
		end else begin
			lane_wr <= take;
			if (|starve) begin
				overrun <= 1'b1;
			end
		end
	end

	// packed entry, last bit on top
	always_ff @(posedge clk) begin
		if (|take) begin
			lane_din <= {in_op == OP_LAST, in_data};
		end
	end

endmodule

// ==== rtl/lane_drain.sv ====
// packet-level round-robin lane drain with downstream credits and upstream credit return
module lane_drain (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic [lane_buf_pkg::NUM_LANES-1:0][lane_buf_pkg::ENTRY_W-1:0] lane_dout,
	input  logic [lane_buf_pkg::NUM_LANES-1:0]                    lane_empty,
	input  logic                                                  out_credit,
	output logic [lane_buf_pkg::NUM_LANES-1:0]                    lane_rd,
	output logic [lane_buf_pkg::NUM_LANES-1:0]                    credit_ret,
	output logic                                                  out_valid,
	output logic [lane_buf_pkg::LANE_BITS-1:0]                    out_lane,
	output logic                                                  out_last,
	output logic [lane_buf_pkg::DATA_W-1:0]                       out_data
);

	import lane_buf_pkg::*;

	// ==============================
	// state
	// ==============================

	drain_state_e           state_q;
	// last lane that finished a packet
	logic [LANE_BITS-1:0]   rr_q;
	// lane being drained
	logic [LANE_BITS-1:0]   cur_q;
	// downstream credits held
	logic [CRD_W-1:0]       crd_q;

	logic                   pick_found;
	logic [LANE_BITS-1:0]   pick_lane;
	logic [ENTRY_W-1:0]     head;
	logic                   send;

	// round robin search
	// walk from farthest to nearest so the lane right after rr_q wins
	always_comb begin
		logic [LANE_BITS-1:0] cand;
		pick_found = 1'b0;
		pick_lane  = rr_q;
		for (int k = NUM_LANES; k >= 1; k--) begin
			cand = rr_q + LANE_BITS'(k);
			if (!lane_empty[cand]) begin
				pick_found = 1'b1;
				pick_lane  = cand;
			end
		end
	end

	assign head = lane_dout[cur_q];

	// read only in burst, with a word and a credit
	assign send    = (state_q == DR_BURST) && !lane_empty[cur_q] && (crd_q != '0);
	assign lane_rd = send ? (NUM_LANES'(1) << cur_q) : '0;

	// ==============================
	// fsm and credit counter
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= DR_PICK;
			// lane 0 served first
			rr_q       <= LANE_BITS'(NUM_LANES - 1);
			cur_q      <= '0;
			crd_q      <= CRD_W'(OUT_CREDITS);
			out_valid  <= 1'b0;
			credit_ret <= '0;
		end else begin
			out_valid  <= send;
			// one credit back per word removed
			credit_ret <= lane_rd;
			// spend at read, refill on pulse
			crd_q      <= crd_q - {{(CRD_W-1){1'b0}}, send} + {{(CRD_W-1){1'b0}}, out_credit};
			case (state_q)
				DR_PICK: begin
					if (pick_found) begin
						state_q <= DR_BURST;
						cur_q   <= pick_lane;
					end
				end
				DR_BURST: begin
					// stay on lane until its last word leaves
					if (send && head[ENTRY_W-1]) begin
						state_q <= DR_PICK;
						rr_q    <= cur_q;
					end
				end
				default: state_q <= DR_PICK;
			endcase
		end
	end

	// output payload, valid one cycle after the read
	always_ff @(posedge clk) begin
		if (send) begin
			out_lane <= cur_q;
			out_last <= head[ENTRY_W-1];
			out_data <= head[DATA_W-1:0];
		end
	end

	// credit counter has no room past all ones
	a_crd_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		!(crd_q == '1 && out_credit && !send))
		else $error("lane_drain downstream credit counter overflow");

endmodule

// ==== rtl/lane_buf_top.sv ====
// four-lane ingress packet buffer joining dispatcher, lane FIFOs and round-robin drain
module lane_buf_top (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_valid,
	input  logic [lane_buf_pkg::LANE_BITS-1:0]    in_lane,
	input  lane_buf_pkg::lane_op_e                in_op,
	input  logic [lane_buf_pkg::DATA_W-1:0]       in_data,
	output logic [lane_buf_pkg::NUM_LANES-1:0]    credit_ret,
	output logic                                  out_valid,
	output logic [lane_buf_pkg::LANE_BITS-1:0]    out_lane,
	output logic                                  out_last,
	output logic [lane_buf_pkg::DATA_W-1:0]       out_data,
	input  logic                                  out_credit,
	output logic                                  overrun
);

	import lane_buf_pkg::*;

	// ==============================
	// lane wiring
	// ==============================

	logic [NUM_LANES-1:0]              lane_wr;
	logic [ENTRY_W-1:0]                lane_din;
	logic [NUM_LANES-1:0]              lane_rd;
	logic [NUM_LANES-1:0][ENTRY_W-1:0] fifo_dout;
	logic [NUM_LANES-1:0]              fifo_empty;
	logic [NUM_LANES-1:0]              fifo_emptyp2;

	// ingress side
	lane_dispatch dispatch_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_lane    (in_lane),
		.in_op      (in_op),
		.in_data    (in_data),
		.credit_ret (credit_ret),
		.lane_wr    (lane_wr),
		.lane_din   (lane_din),
		.overrun    (overrun)
	);

	// one fifo per lane, shared write data
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		fifo_flop_out #(
			.WIDTH      (ENTRY_W),
			.DEPTH_BITS (LANE_DEPTH_BITS)
		) fifo_i (
			.clk     (clk),
			.rst_n   (rst_n),
			.din     (lane_din),
			.wr      (lane_wr[i]),
			.rd      (lane_rd[i]),
			.dout    (fifo_dout[i]),
			.count   (),
			.full    (),
			.empty   (fifo_empty[i]),
			.emptyp2 (fifo_emptyp2[i])
		);

		// refill path keeps the head valid when a second word sits behind it
		a_refill: assert property (@(posedge clk) disable iff (!rst_n)
			fifo_emptyp2[i] && lane_rd[i] && !lane_wr[i] |=> !fifo_empty[i])
			else $error("lane %0d lost its refill word", i);
	end

	// egress side
	lane_drain drain_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.lane_dout  (fifo_dout),
		.lane_empty (fifo_empty),
		.out_credit (out_credit),
		.lane_rd    (lane_rd),
		.credit_ret (credit_ret),
		.out_valid  (out_valid),
		.out_lane   (out_lane),
		.out_last   (out_last),
		.out_data   (out_data)
	);

endmodule

// ==== dv/lane_buf_tb.sv ====
// testbench for the four-lane packet buffer, plays file vectors against per-lane reference queues
module lane_buf_tb;

	import lane_buf_pkg::*;

	// ==============================
	// vector storage
	// ==============================

	// six hex words per vector: gap, lane, op, data, credit, kind
	localparam int FIELDS       = 6;
	localparam int MAX_VECS     = 64;
	localparam int DRAIN_CYCLES = 400;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic [LANE_BITS-1:0] in_lane;
	lane_op_e             in_op;
	logic [DATA_W-1:0]    in_data;
	logic [NUM_LANES-1:0] credit_ret;
	logic                 out_valid;
	logic [LANE_BITS-1:0] out_lane;
	logic                 out_last;
	logic [DATA_W-1:0]    out_data;
	logic                 out_credit;
	logic                 overrun;

	logic [15:0] vec_mem [MAX_VECS*FIELDS];
	// expected words per lane, {last, data}
	logic [DATA_W:0] ref_q [NUM_LANES][$];

	// source side credit model and per-lane tallies
	int up_crd [NUM_LANES];
	int ret_cnt [NUM_LANES];
	int rd_cnt [NUM_LANES];
	// returned last cycle, usable once the source has sampled it
	logic [NUM_LANES-1:0] ret_prev = '0;
	int n_vecs;
	int errors = 0;
	int checks = 0;
	int sends = 0;
	int pulses = 0;
	int cycles = 0;
	int limit = 1000000;
	// packet currently going out
	bit pkt_open = 1'b0;
	logic [LANE_BITS-1:0] open_lane = '0;
	// set while no downstream credit is given
	bit quiet = 1'b0;
	bit overrun_sent = 1'b0;

	lane_buf_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_lane    (in_lane),
		.in_op      (in_op),
		.in_data    (in_data),
		.credit_ret (credit_ret),
		.out_valid  (out_valid),
		.out_lane   (out_lane),
		.out_last   (out_last),
		.out_data   (out_data),
		.out_credit (out_credit),
		.overrun    (overrun)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// cycle limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, run did not finish within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ==============================
	// checks on the registered outputs
	// ==============================

	task automatic check_outputs();
		logic [DATA_W:0]      exp;
		logic [NUM_LANES-1:0] exp_ret;
		// credit return pulses with the word it frees
		exp_ret = out_valid ? (NUM_LANES'(1) << out_lane) : '0;
		checks++;
		if (credit_ret !== exp_ret) begin
			$display("FAIL %0t credit_ret exp %b got %b", $time, exp_ret, credit_ret);
			errors++;
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (ret_prev[l]) begin
				up_crd[l]++;
			end
			if (credit_ret[l]) begin
				ret_cnt[l]++;
			end
		end
		ret_prev = credit_ret;
		if (overrun && !overrun_sent) begin
			$display("FAIL %0t overrun exp 0 got 1", $time);
			errors++;
		end
		if (!out_valid) begin
			return;
		end
		sends++;
		if (quiet) begin
			$display("word sent at %0t while no downstream credit was given", $time);
			errors++;
		end
		if (sends > OUT_CREDITS + pulses) begin
			$display("more words sent than downstream credits at %0t", $time);
			errors++;
		end
		// no interleaving inside a packet
		if (pkt_open && out_lane != open_lane) begin
			$display("FAIL %0t out_lane exp %0d got %0d", $time, open_lane, out_lane);
			errors++;
		end
		if (ref_q[out_lane].size() == 0) begin
			$display("word on lane %0d at %0t with nothing expected", out_lane, $time);
			errors++;
		end else begin
			exp = ref_q[out_lane].pop_front();
			checks++;
			if (out_data !== exp[DATA_W-1:0]) begin
				$display("FAIL %0t out_data exp %h got %h", $time, exp[DATA_W-1:0], out_data);
				errors++;
			end
			if (out_last !== exp[DATA_W]) begin
				$display("FAIL %0t out_last exp %b got %b", $time, exp[DATA_W], out_last);
				errors++;
			end
		end
		rd_cnt[out_lane]++;
		pkt_open  = !out_last;
		open_lane = out_lane;
	endtask

	// falling edge, check, then idle inputs with an optional credit pulse
	task automatic step_cycle(input bit credit);
		@(negedge clk);
		check_outputs();
		in_valid   = 1'b0;
		out_credit = credit;
		if (credit) begin
			pulses++;
			quiet = 1'b0;
		end
	endtask

	function automatic bit queues_empty();
		for (int l = 0; l < NUM_LANES; l++) begin
			if (ref_q[l].size() != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// ==============================
	// stimulus
	// ==============================

	initial begin
		int                   base;
		int                   gap;
		int                   kind;
		logic [LANE_BITS-1:0] lane;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_lane    = '0;
		in_op      = OP_DATA;
		in_data    = '0;
		out_credit = 1'b0;
		for (int l = 0; l < NUM_LANES; l++) begin
			up_crd[l]  = 1 << LANE_DEPTH_BITS;
			ret_cnt[l] = 0;
			rd_cnt[l]  = 0;
		end
		$readmemh("dv/lane_buf_vectors.txt", vec_mem);
		// ffff in the gap column closes the list
		n_vecs = 0;
		while (n_vecs < MAX_VECS && vec_mem[n_vecs*FIELDS] != 16'hffff) begin
			n_vecs++;
		end
		limit = 20 * n_vecs + DRAIN_CYCLES;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int v = 0; v < n_vecs; v++) begin
			base = v * FIELDS;
			gap  = int'(vec_mem[base]);
			lane = LANE_BITS'(vec_mem[base+1]);
			kind = int'(vec_mem[base+5]);
			repeat (gap) step_cycle(1'b0);
			step_cycle(vec_mem[base+4][0]);
			// source holds a word back until its lane has credit
			while (kind != 1 && up_crd[lane] == 0) begin
				step_cycle(sends > pulses);
			end
			if (kind == 1 && up_crd[lane] != 0) begin
				$display("overrun vector %0d found lane %0d still holding credit", v, lane);
				errors++;
			end else begin
				in_valid = 1'b1;
				in_lane  = lane;
				in_op    = lane_op_e'(vec_mem[base+2][0]);
				in_data  = vec_mem[base+3];
				if (kind == 1) begin
					overrun_sent = 1'b1;
				end else begin
					up_crd[lane]--;
					ref_q[lane].push_back({vec_mem[base+2][0], vec_mem[base+3]});
				end
			end
			quiet = (kind == 2);
		end

		// drain, topping up downstream credit as it is spent
		step_cycle(1'b0);
		while (!queues_empty()) begin
			step_cycle(sends > pulses);
		end
		repeat (8) step_cycle(1'b0);

		for (int l = 0; l < NUM_LANES; l++) begin
			if (up_crd[l] != (1 << LANE_DEPTH_BITS)) begin
				$display("FAIL %0t up_crd[%0d] exp %0d got %0d", $time, l,
					1 << LANE_DEPTH_BITS, up_crd[l]);
				errors++;
			end
			if (ret_cnt[l] != rd_cnt[l]) begin
				$display("FAIL %0t credit_ret[%0d] count exp %0d got %0d", $time, l,
					rd_cnt[l], ret_cnt[l]);
				errors++;
			end
		end
		if (overrun_sent && overrun !== 1'b1) begin
			$display("FAIL %0t overrun exp 1 got %b", $time, overrun);
			errors++;
		end
		$display("vectors %0d, checks %0d, words out %0d, errors %0d", n_vecs, checks, sends,
			errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/lane_buf_pkg.sv
rtl/flop_fifo.sv
rtl/fifo_flop_out.sv
rtl/lane_dispatch.sv
rtl/lane_drain.sv
rtl/lane_buf_top.sv
dv/lane_buf_tb.sv

// ==== Makefile ====
# Verilator build and run for the lane buffer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module lane_buf_tb -f sources.f -o lane_buf_sim
	@out="$$(./obj_dir/lane_buf_sim)"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// ==== dv/lane_buf_vectors.txt ====
// gap lane op data credit kind, all hex; op 1 is a last word, credit 1 pulses out_credit
// kind 0 normal, 1 deliberate overrun, 2 no downstream credit span; ffff gap ends the list
// lane 0 packet on the initial downstream credits
1 0 0 a000 0 0
0 0 0 a001 0 0
0 0 0 a002 0 0
0 0 1 a003 0 0
// no downstream credit, lanes fill and lane 2 runs dry
8 1 0 b100 0 2
0 2 0 c200 0 2
0 1 0 b101 0 2
0 2 0 c201 0 2
0 2 0 c202 0 2
0 3 0 d300 0 2
0 2 0 c203 0 2
0 1 1 b102 0 2
0 2 0 c204 0 2
0 2 0 c205 0 2
0 3 1 d301 0 2
0 2 0 c206 0 2
0 2 1 c207 0 2
// sent without credit, must be dropped
2 2 0 dead 0 1
// credits flow again, mixed lanes
3 0 0 a010 1 0
0 3 0 d310 0 0
1 0 0 a011 1 0
0 1 0 b110 0 0
0 3 1 d311 1 0
0 1 0 b111 0 0
2 0 1 a012 1 0
0 1 1 b112 1 0
// lane 2 refills once its packet drains
0 2 0 c210 1 0
0 2 0 c211 0 0
0 2 1 c212 1 0
// single word packets through the bypass path
4 3 1 d320 1 0
3 0 1 a020 1 0
3 1 1 b120 1 0
0 2 1 c220 0 0
// back to back burst on lane 0
0 0 0 a030 1 0
0 0 0 a031 1 0
0 0 0 a032 0 0
0 0 0 a033 1 0
0 0 1 a034 1 0
ffff 0 0 0000 0 0
